// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = mem_sys_tb
FILELIST  = mem_sys.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: cache_controller.sv
`timescale 1ns/1ps

module cache_controller import mem_sys_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     i_iacc,    // Instruction fetch pending
	input  logic     i_dacc,    // Data access pending
	input  logic     i_write,   // Data access is a write
	input  addr_u    i_iaddr,
	input  addr_u    i_daddr,
	input  word_t    i_wrdata,
	input  logic     i_ihit,
	input  logic     i_dhit,
	input  logic     i_dirty,   // Line at data index is dirty
	input  logic [7:0] i_dtag,  // Tag of line at data index
	input  line_t    i_dline,   // Line at data index
	input  line_t    i_mline,   // Line returned by memory
	input  logic     i_mem_rdy,
	output mem_req_t o_mreq,
	output logic     o_iwe,
	output line_t    o_iline,
	output logic     o_dwe,
	output line_t    o_dline,
	output logic     o_ddirty,
	output logic     o_rdy
);

	localparam logic [1:0] START        = 2'b00;
	localparam logic [1:0] SPARE        = 2'b01; // Unused encoding, acts as START
	localparam logic [1:0] SERVICE_MISS = 2'b10;
	localparam logic [1:0] WRITE_BACK   = 2'b11;

	logic [1:0]  state;
	logic [1:0]  next_state;
	logic        m_re;
	logic        m_we;
	logic [13:0] m_addr;
	logic        d_miss;
	logic        i_miss;

	// Replace one word of a line, rest untouched
	function automatic line_t merge_word(line_t line, word_t w, logic [1:0] off);
		line_t merged;
		merged = line;
		merged[{off, 4'b0000} +: 16] = w;
		return merged;
	endfunction

	assign d_miss = i_dacc & ~i_dhit;
	assign i_miss = i_iacc & ~i_ihit;

	assign o_mreq = '{re: m_re, we: m_we, addr: m_addr, data: i_dline}; // Victim line as write data

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= START;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		m_re       = 1'b0;
		m_we       = 1'b0;
		m_addr     = '0;
		o_iwe      = 1'b0;
		o_iline    = '0;
		o_dwe      = 1'b0;
		o_dline    = '0;
		o_ddirty   = 1'b0;
		o_rdy      = 1'b0;
		case (state)
			START, SPARE: begin
				if (d_miss) begin // Data misses go first
					if (i_dirty) begin
						m_we       = 1'b1;
						m_addr     = {i_dtag, i_daddr.fld.index}; // Victim line address
						next_state = WRITE_BACK;
					end else begin
						m_re       = 1'b1;
						m_addr     = {i_daddr.fld.tag, i_daddr.fld.index};
						next_state = SERVICE_MISS;
					end
				end else if (i_miss) begin
					m_re       = 1'b1;
					m_addr     = {i_iaddr.fld.tag, i_iaddr.fld.index};
					next_state = SERVICE_MISS;
				end else begin
					o_rdy = 1'b1; // Everything active hits
					if (i_dacc && i_write) begin
						o_dwe    = 1'b1;
						o_dline  = merge_word(i_dline, i_wrdata, i_daddr.fld.offset);
						o_ddirty = 1'b1;
					end
				end
			end
			SERVICE_MISS: begin
				m_re = 1'b1; // Held through the mem_rdy cycle
				if (d_miss) begin
					m_addr = {i_daddr.fld.tag, i_daddr.fld.index};
				end else begin
					m_addr = {i_iaddr.fld.tag, i_iaddr.fld.index};
				end
				if (i_mem_rdy) begin
					next_state = START; // Access hits next cycle
					if (d_miss) begin
						o_dwe = 1'b1;
						if (i_write) begin
							o_dline  = merge_word(i_mline, i_wrdata, i_daddr.fld.offset);
							o_ddirty = 1'b1;
						end else begin
							o_dline = i_mline; // Clean fill
						end
					end else begin
						o_iwe   = 1'b1;
						o_iline = i_mline;
					end
				end
			end
			WRITE_BACK: begin
				m_we   = 1'b1;
				m_addr = {i_dtag, i_daddr.fld.index};
				if (i_mem_rdy) begin
					next_state = SERVICE_MISS; // Refill follows
				end
			end
		endcase
	end

endmodule

// File: dcache.sv
`timescale 1ns/1ps

module dcache import mem_sys_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  addr_u      i_addr,
	input  logic       i_we,    // Fill or merge write
	input  line_t      i_line,
	input  logic       i_dirty, // Dirty bit stored with the line
	output logic       o_hit,
	output logic       o_dirty, // Held line needs write-back
	output logic [7:0] o_tag,   // Held line tag, hit or not
	output line_t      o_line,
	output word_t      o_word
);

	line_t       lines [64];
	logic [7:0]  tags  [64];
	logic [63:0] valid;
	logic [63:0] dirty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_we) begin
			valid[i_addr.fld.index] <= 1'b1;
			dirty[i_addr.fld.index] <= i_dirty; // Clean fill clears it
		end
	end

	always_ff @(posedge clk) begin
		if (i_we) begin
			lines[i_addr.fld.index] <= i_line;
			tags[i_addr.fld.index]  <= i_addr.fld.tag;
		end
	end

	assign o_hit   = valid[i_addr.fld.index] && (tags[i_addr.fld.index] == i_addr.fld.tag);
	assign o_dirty = valid[i_addr.fld.index] && dirty[i_addr.fld.index];
	assign o_tag   = tags[i_addr.fld.index];
	assign o_line  = lines[i_addr.fld.index];
	assign o_word  = lines[i_addr.fld.index][{i_addr.fld.offset, 4'b0000} +: 16];

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache import mem_sys_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  addr_u i_addr,
	input  logic  i_we,   // Line fill
	input  line_t i_line,
	output logic  o_hit,
	output word_t o_word
);

	line_t       lines [64];
	logic [7:0]  tags  [64];
	logic [63:0] valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (i_we) begin
			valid[i_addr.fld.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_we) begin
			lines[i_addr.fld.index] <= i_line;
			tags[i_addr.fld.index]  <= i_addr.fld.tag;
		end
	end

	assign o_hit  = valid[i_addr.fld.index] && (tags[i_addr.fld.index] == i_addr.fld.tag);
	assign o_word = lines[i_addr.fld.index][{i_addr.fld.offset, 4'b0000} +: 16]; // Word by offset

endmodule

// File: mem_sys.f
+incdir+.
mem_sys_pkg.sv
cache_controller.sv
icache.sv
dcache.sv
unified_mem.sv
mem_sys.sv
tb_clk_gen.sv
mem_sys_chk.sv
mem_sys_tb.sv

// File: mem_sys.sv
`timescale 1ns/1ps

module mem_sys import mem_sys_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_iacc,
	input  addr_u i_iaddr,
	input  logic  i_dacc,
	input  addr_u i_daddr,
	input  logic  i_read,
	input  logic  i_write,
	input  word_t i_wrdata,
	output word_t o_instr,
	output word_t o_rdata,
	output logic  o_rdy
);

	logic       d_acc;     // Data access with a real operation
	logic       ihit;
	logic       dhit;
	logic       ddirty;
	logic [7:0] dtag;
	line_t      dline;
	line_t      mline;
	logic       mem_rdy;
	mem_req_t   mreq;
	logic       iwe;
	line_t      iline;
	logic       dwe;
	line_t      dline_w;   // Fill or merge line into the data cache
	logic       ddirty_in;

	assign d_acc = i_dacc & (i_read | i_write);

	cache_controller u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_iacc    (i_iacc),
		.i_dacc    (d_acc),
		.i_write   (i_write),
		.i_iaddr   (i_iaddr),
		.i_daddr   (i_daddr),
		.i_wrdata  (i_wrdata),
		.i_ihit    (ihit),
		.i_dhit    (dhit),
		.i_dirty   (ddirty),
		.i_dtag    (dtag),
		.i_dline   (dline),
		.i_mline   (mline),
		.i_mem_rdy (mem_rdy),
		.o_mreq    (mreq),
		.o_iwe     (iwe),
		.o_iline   (iline),
		.o_dwe     (dwe),
		.o_dline   (dline_w),
		.o_ddirty  (ddirty_in),
		.o_rdy     (o_rdy)
	);

	icache u_icache (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_addr (i_iaddr),
		.i_we   (iwe),
		.i_line (iline),
		.o_hit  (ihit),
		.o_word (o_instr)
	);

	dcache u_dcache (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_addr  (i_daddr),
		.i_we    (dwe),
		.i_line  (dline_w),
		.i_dirty (ddirty_in),
		.o_hit   (dhit),
		.o_dirty (ddirty),
		.o_tag   (dtag),
		.o_line  (dline),
		.o_word  (o_rdata)
	);

	unified_mem u_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_req  (mreq),
		.o_rdy  (mem_rdy),
		.o_line (mline)
	);

endmodule

// File: mem_sys_chk.sv
`timescale 1ns/1ps

module mem_sys_chk import mem_sys_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     i_iacc,
	input logic     i_dacc,    // Data access with a real operation
	input logic     i_ihit,
	input logic     i_dhit,
	input logic     i_mem_rdy,
	input mem_req_t i_mreq,
	input logic     i_iwe,
	input logic     i_dwe,
	input logic     i_rdy
);

	int assert_errs = 0; // Failed assertions so far

	// One memory operation at a time
	assert property (@(posedge clk) disable iff (!rst_n) !(i_mreq.re && i_mreq.we))
		else begin
			assert_errs++;
			$error("memory read and write requested together");
		end

	// Request held until the memory answers
	assert property (@(posedge clk) disable iff (!rst_n)
		(i_mreq.re || i_mreq.we) && !i_mem_rdy |=> $stable(i_mreq))
		else begin
			assert_errs++;
			$error("memory request changed before mem_rdy");
		end

	// Ready only when every active access hits
	assert property (@(posedge clk) disable iff (!rst_n)
		i_rdy |-> (!i_iacc || i_ihit) && (!i_dacc || i_dhit))
		else begin
			assert_errs++;
			$error("o_rdy raised while an access misses");
		end

	// Quiet first cycle out of reset
	assert property (@(posedge clk) $rose(rst_n) |-> !(i_mreq.re || i_mreq.we || i_iwe || i_dwe))
		else begin
			assert_errs++;
			$error("enable high in the first cycle after reset");
		end

endmodule

bind cache_controller mem_sys_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.i_iacc    (i_iacc),
	.i_dacc    (i_dacc),
	.i_ihit    (i_ihit),
	.i_dhit    (i_dhit),
	.i_mem_rdy (i_mem_rdy),
	.i_mreq    (o_mreq),
	.i_iwe     (o_iwe),
	.i_dwe     (o_dwe),
	.i_rdy     (o_rdy)
);

// File: mem_sys_pkg.sv
package mem_sys_pkg;

	typedef logic [15:0] word_t; // One data or instruction word
	typedef logic [63:0] line_t; // Four words, word 0 in bits 15:0

	// Word address split into cache fields, high bits first
	typedef struct packed {
		logic [7:0] tag;    // Compared against the tag array
		logic [5:0] index;  // Selects one of 64 lines
		logic [1:0] offset; // Selects a word in the line
	} addr_fields_t;

	// Same 16 bits seen flat or as cache fields
	typedef union packed {
		logic [15:0]  raw; // Flat word address
		addr_fields_t fld; // Tag, index and offset view
	} addr_u;

	// Line request from the controller to the backing memory
	typedef struct packed {
		logic        re;   // Line read
		logic        we;   // Line write
		logic [13:0] addr; // Line address, tag and index
		line_t       data; // Write-back line
	} mem_req_t;

endpackage

// File: mem_sys_settings.svh
`ifndef MEM_SYS_SETTINGS_SVH
`define MEM_SYS_SETTINGS_SVH

// Backing memory timing
// Cycles from the first held request to the mem_rdy pulse
// Legal range is 1 to 15, set by the 4-bit latency counter
`define MEM_LATENCY 4

// Backing memory contents at time zero
// Each word starts as its own word address XOR this key
`define MEM_PATTERN 16'h5a5a

`endif

// File: mem_sys_tb.sv
`timescale 1ns/1ps
`include "mem_sys_settings.svh"

module mem_sys_tb import mem_sys_pkg::*; ();

	localparam int TIMEOUT = 4 * `MEM_LATENCY + 8; // Cycles allowed per access
	localparam int SETTLE  = 5;                    // Sample point after the falling edge

	logic        clk;
	logic        rst_n;
	logic        iacc;
	logic        dacc;
	logic        rd;
	logic        wr;
	addr_u       iaddr;
	addr_u       daddr;
	word_t       wrdata;
	word_t       instr;
	word_t       rdata;
	logic        rdy;
	word_t       model [word_t]; // Written words, the rest follow the pattern
	logic [31:0] lfsr_state;
	int          errors;
	int          timeouts;

	tb_clk_gen u_clk (.o_clk(clk), .o_rst_n(rst_n));

	mem_sys i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_iacc   (iacc),
		.i_iaddr  (iaddr),
		.i_dacc   (dacc),
		.i_daddr  (daddr),
		.i_read   (rd),
		.i_write  (wr),
		.i_wrdata (wrdata),
		.o_instr  (instr),
		.o_rdata  (rdata),
		.o_rdy    (rdy)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic word_t expected(input word_t a);
		if (model.exists(a)) begin
			return model[a];
		end
		return a ^ `MEM_PATTERN; // Untouched word
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Caller sits on a falling edge; returns on a falling edge with the bus idle
	task automatic run_access(input string name, input logic ia, input addr_u ia_addr,
		input logic da, input addr_u da_addr, input logic w, input word_t wd,
		output word_t got_i, output word_t got_d);
		int cycles;
		cycles = 0;
		iacc   = ia;
		iaddr  = ia_addr;
		dacc   = da;
		daddr  = da_addr;
		rd     = da & ~w;
		wr     = da & w;
		wrdata = wd;
		#SETTLE;
		while (!rdy && cycles < TIMEOUT) begin
			@(negedge clk);
			#SETTLE;
			cycles++;
		end
		got_i = instr; // Valid in the ready cycle
		got_d = rdata;
		if (!rdy) begin
			timeouts++;
			$display("Timeout: %s saw no ready within %0d cycles", name, TIMEOUT);
		end
		@(negedge clk); // Write committed at the rising edge before
		iacc = 1'b0;
		dacc = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
	endtask

	task automatic fetch_check(input string name, input word_t a);
		word_t gi;
		word_t gd;
		run_access(name, 1'b1, a, 1'b0, '0, 1'b0, '0, gi, gd);
		check_word(name, a ^ `MEM_PATTERN, gi); // Fetch lines are never written
	endtask

	task automatic read_check(input string name, input word_t a);
		word_t gi;
		word_t gd;
		run_access(name, 1'b0, '0, 1'b1, a, 1'b0, '0, gi, gd);
		check_word(name, expected(a), gd);
	endtask

	task automatic write_word(input string name, input word_t a, input word_t d);
		word_t gi;
		word_t gd;
		run_access(name, 1'b0, '0, 1'b1, a, 1'b1, d, gi, gd);
		model[a] = d;
	endtask

	task automatic cold_fetch();
		fetch_check("cold_fetch_miss", 16'h2104);
		fetch_check("cold_fetch_same_line", 16'h2107);
	endtask

	task automatic read_hit_miss();
		read_check("read_miss", 16'h3010);
		read_check("read_hit", 16'h3013);
	endtask

	task automatic write_then_read();
		write_word("write_word", 16'h4022, 16'hbeef);
		read_check("read_written", 16'h4022);
		read_check("read_neighbour_0", 16'h4020);
		read_check("read_neighbour_1", 16'h4021);
		read_check("read_neighbour_3", 16'h4023);
	endtask

	// Same index 0x0c, tags 0x50 and 0x60
	task automatic dirty_eviction();
		write_word("evict_write_a", 16'h5031, 16'hc0de);
		read_check("evict_read_b", 16'h6032);
		read_check("evict_read_a", 16'h5031);
	endtask

	task automatic dual_miss();
		word_t gi;
		word_t gd;
		run_access("dual_miss", 1'b1, 16'h7044, 1'b1, 16'h8050, 1'b0, '0, gi, gd);
		check_word("dual_miss_instr", 16'h7044 ^ `MEM_PATTERN, gi);
		check_word("dual_miss_data", expected(16'h8050), gd);
	endtask

	// Tags 0x10 to 0x13 over indexes 0 to 7, so lines collide often
	task automatic random_traffic();
		logic [15:0] tag_lo;
		logic [15:0] idx;
		logic [15:0] off;
		logic [15:0] op;
		logic [15:0] data;
		word_t       a;
		for (int n = 0; n < 60; n++) begin
			tag_lo = take_bits(2);
			idx    = take_bits(3);
			off    = take_bits(2);
			op     = take_bits(1);
			data   = take_bits(16);
			a      = {6'b000100, tag_lo[1:0], 3'b000, idx[2:0], off[1:0]};
			if (op[0]) begin
				write_word($sformatf("random_write_%0d", n), a, data);
			end else begin
				read_check($sformatf("random_read_%0d", n), a);
			end
		end
	endtask

	initial begin
		int waited;
		errors     = 0;
		timeouts   = 0;
		lfsr_state = 32'h7f899cca;
		iacc       = 1'b0;
		dacc       = 1'b0;
		rd         = 1'b0;
		wr         = 1'b0;
		iaddr      = '0;
		daddr      = '0;
		wrdata     = '0;
		waited     = 0;
		while (rst_n !== 1'b1 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (rst_n !== 1'b1) begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
		@(negedge clk);
		cold_fetch();
		read_hit_miss();
		write_then_read();
		dirty_eviction();
		dual_miss();
		random_traffic();
		$display("Errors %0d, timeouts %0d, assertion failures %0d",
			errors, timeouts, i_dut.u_ctrl.u_chk.assert_errs);
		if (errors == 0 && timeouts == 0 && i_dut.u_ctrl.u_chk.assert_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk; // 20 ns period
	end

	initial begin
		o_rst_n = 1'b0; // Held for 5 cycles
		repeat (5) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1; // Released away from the rising edge
	end

endmodule

// File: unified_mem.sv
`timescale 1ns/1ps
`include "mem_sys_settings.svh"

module unified_mem import mem_sys_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t i_req,
	output logic     o_rdy,  // One-cycle ready pulse
	output line_t    o_line  // Read line, valid with o_rdy
);

	localparam int         LINES    = 1 << 14;
	localparam logic [3:0] LAT_LAST = 4'(`MEM_LATENCY - 1); // Count at the edge before the pulse

	line_t      mem [LINES];
	logic [3:0] lat_cnt;
	logic       active;
	logic       fire;

	// Fixed pattern at time zero, word address XOR key
	initial begin
		for (int i = 0; i < LINES; i++) begin
			for (int w = 0; w < 4; w++) begin
				mem[i][w*16 +: 16] = {i[13:0], w[1:0]} ^ `MEM_PATTERN;
			end
		end
	end

	assign active = i_req.re | i_req.we;
	assign fire   = active && !o_rdy && (lat_cnt == LAT_LAST); // Last wait cycle

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lat_cnt <= '0;
			o_rdy   <= 1'b0;
		end else if (o_rdy) begin
			lat_cnt <= '0; // Ready for the next request
			o_rdy   <= 1'b0;
		end else if (active) begin
			lat_cnt <= lat_cnt + 4'd1;
			o_rdy   <= fire;
		end
	end

	always_ff @(posedge clk) begin
		if (fire && i_req.re) begin
			o_line <= mem[i_req.addr]; // Lands with the pulse
		end
		if (o_rdy && i_req.we) begin
			mem[i_req.addr] <= i_req.data; // Stored on the pulse edge
		end
	end

endmodule
